/* common/dmm_regs_pkg.sv */
/*
  dmm control register map
  field widths of the SPI control frame and the register addresses
*/
package dmm_regs_pkg;

  ////////////////////////////////////////////////////////////
  // frame layout

  // address byte first, then the data word, both MSB first
  localparam int ADDR_W  = 8;
  localparam int DATA_W  = 24;
  localparam int FRAME_W = ADDR_W + DATA_W;

  ////////////////////////////////////////////////////////////
  // register addresses

  // status led, bit 0 only
  localparam logic [ADDR_W-1:0] REG_LED  = 8'd1;

  // conditioning mode select, low 2 bits
  localparam logic [ADDR_W-1:0] REG_MODE = 8'd2;

  // direct conditioning vector, low 13 bits
  localparam logic [ADDR_W-1:0] REG_COND = 8'd3;

  // direct monitor value, low 8 bits
  localparam logic [ADDR_W-1:0] REG_MON  = 8'd4;

endpackage

/* common/cond_pkg.sv */
/*
  analog front-end conditioning types
  mode encoding, switch vector layout and mux select codes
*/
package cond_pkg;

  // conditioning mode, as held in the mode register
  typedef enum logic [1:0] {
    MODE_OFF    = 2'd0,
    MODE_DIRECT = 2'd1,
    MODE_SWEEP  = 2'd2,
    MODE_ACCUM  = 2'd3
  } cond_mode_t;

  // switch vector driven to the front end, msb first
  // each mux field is enable then 3-bit channel
  typedef struct packed {
    logic       pc_sw;
    logic [3:0] himux2;
    logic [3:0] himux;
    logic [3:0] azmux;
  } cond_vec_t;

  ////////////////////////////////////////////////////////////
  // 1-of-8 mux select codes

  // s4, ground, clears charge on the input cap
  localparam logic [3:0] MUX_GND    = 4'b1011;
  // s1, dcv source hi
  localparam logic [3:0] MUX_SRC_HI = 4'b1000;
  // s2 on himux, routes the himux2 output through
  localparam logic [3:0] MUX_HIMUX2 = 4'b1001;
  // enable low, all channels open
  localparam logic [3:0] MUX_OFF    = 4'b0000;

endpackage

/* common/reg_bus_if.sv */
/*
  register bus
  four-phase write handshake plus combinational read port
*/
interface reg_bus_if;
  import dmm_regs_pkg::*;

  // write request, held with address and data until ack
  logic              req;
  logic              ack;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;

  // read port, rd_data follows rd_addr without a clock
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;

  modport slave (
    output req, wr_addr, wr_data, rd_addr,
    input  ack, rd_data
  );

  modport regs (
    input  req, wr_addr, wr_data, rd_addr,
    output ack, rd_data
  );

endinterface

/* spi/spi_reg_slave.sv */
/*
  spi register slave
  oversamples the spi pins on clk, shifts in 32-bit frames, returns the
  addressed register on miso and hands complete frames to the register file
*/
module spi_reg_slave (
  input  logic     clk,
  input  logic     reset,
  input  logic     spi_clk,
  input  logic     spi_cs,
  input  logic     spi_mosi,
  output logic     spi_miso,
  reg_bus_if.slave bus
);
  import dmm_regs_pkg::*;

  // one spare count so an overlong frame never wraps back to 32
  localparam int CNT_W = $clog2(FRAME_W) + 1;

  logic [2:0]         clk_sync;
  logic [2:0]         cs_sync;
  logic [1:0]         mosi_sync;
  logic               sclk_rise;
  logic               sclk_fall;
  logic               cs_rise;
  logic               cs_fall;
  logic               cs_active;
  logic               frame_ok;
  logic               launch;
  logic               pend;
  logic [CNT_W-1:0]   bit_cnt;
  logic [FRAME_W-1:0] shift_q;
  logic [DATA_W-1:0]  tx_q;

  ////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect

  // two flops per pin, the third clk/cs stage is edge history only
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      clk_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end
    else
    begin
      clk_sync  <= {clk_sync[1:0], spi_clk};
      cs_sync   <= {cs_sync[1:0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
    end
  end

  assign sclk_rise = clk_sync[1] & ~clk_sync[2];
  assign sclk_fall = ~clk_sync[1] & clk_sync[2];
  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_fall   = ~cs_sync[1] & cs_sync[2];
  // cs is active low
  assign cs_active = ~cs_sync[1];

  ////////////////////////////////////////////////////////////
  // frame shift in

  // bit count saturates, restarted by each new cs assertion
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (cs_active && sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise)
      shift_q <= {shift_q[FRAME_W-2:0], mosi_sync[1]};
  end

  // latch read address as the eighth address bit arrives
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bus.rd_addr <= '0;
    else if (cs_active && sclk_rise && bit_cnt == CNT_W'(ADDR_W - 1))
      bus.rd_addr <= {shift_q[ADDR_W-2:0], mosi_sync[1]};
  end

  ////////////////////////////////////////////////////////////
  // read data out on miso

  // first falling edge after the address byte loads the register value,
  // later falling edges shift it out msb first
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      spi_miso <= 1'b0;
    else if (!cs_active)
      spi_miso <= 1'b0;
    else if (sclk_fall && bit_cnt == CNT_W'(ADDR_W))
      spi_miso <= bus.rd_data[DATA_W-1];
    else if (sclk_fall && bit_cnt > CNT_W'(ADDR_W))
      spi_miso <= tx_q[DATA_W-1];
  end

  always_ff @(posedge clk)
  begin
    if (sclk_fall && bit_cnt == CNT_W'(ADDR_W))
      tx_q <= {bus.rd_data[DATA_W-2:0], 1'b0};
    else if (sclk_fall)
      tx_q <= {tx_q[DATA_W-2:0], 1'b0};
  end

  ////////////////////////////////////////////////////////////
  // write handshake

  // only a frame of exactly FRAME_W bits is committed
  assign frame_ok = cs_rise && bit_cnt == CNT_W'(FRAME_W);
  // next req waits for ack of the previous one to drop
  assign launch   = pend & ~bus.req & ~bus.ack;

  always_ff @(posedge clk)
  begin
    if (frame_ok)
    begin
      bus.wr_addr <= shift_q[FRAME_W-1 -: ADDR_W];
      bus.wr_data <= shift_q[DATA_W-1:0];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pend    <= 1'b0;
      bus.req <= 1'b0;
    end
    else
    begin
      pend <= frame_ok | (pend & ~launch);
      if (launch)
        bus.req <= 1'b1;
      else if (bus.req && bus.ack)
        bus.req <= 1'b0;
    end
  end

endmodule

/* rtl/ctrl_regs.sv */
/*
  control register file
  takes handshaked writes from the spi slave and serves reads back
*/
module ctrl_regs (
  input  logic                 clk,
  input  logic                 reset,
  reg_bus_if.regs              bus,
  output logic                 led,
  output cond_pkg::cond_mode_t mode,
  output cond_pkg::cond_vec_t  cond_direct,
  output logic [7:0]           mon_direct
);
  import dmm_regs_pkg::*;
  import cond_pkg::*;

  localparam int COND_W = $bits(cond_vec_t);

  logic wr_en;

  // store once, in the cycle between req rising and ack rising
  assign wr_en = bus.req & ~bus.ack;

  // ack mirrors req one cycle late, covering both handshake edges
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bus.ack <= 1'b0;
    else
      bus.ack <= bus.req;
  end

  ////////////////////////////////////////////////////////////
  // write decode

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      led         <= 1'b0;
      mode        <= MODE_OFF;
      cond_direct <= '0;
      mon_direct  <= '0;
    end
    else if (wr_en)
    begin
      // unmapped addresses are acked and dropped
      case (bus.wr_addr)
        REG_LED:  led         <= bus.wr_data[0];
        REG_MODE: mode        <= cond_mode_t'(bus.wr_data[1:0]);
        REG_COND: cond_direct <= cond_vec_t'(bus.wr_data[COND_W-1:0]);
        REG_MON:  mon_direct  <= bus.wr_data[7:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read decode

  // unused upper bits and unmapped addresses read zero
  always_comb
  begin
    bus.rd_data = '0;
    case (bus.rd_addr)
      REG_LED:  bus.rd_data[0]          = led;
      REG_MODE: bus.rd_data[1:0]        = mode;
      REG_COND: bus.rd_data[COND_W-1:0] = cond_direct;
      REG_MON:  bus.rd_data[7:0]        = mon_direct;
      default:  ;
    endcase
  end

endmodule

/* rtl/cond_pattern_gen.sv */
/*
  conditioning pattern generator
  free-running sweep count for bench checks and the two-phase
  charge-accumulation sequence for the input cap
*/
module cond_pattern_gen #(
  parameter int PHASE_CYCLES = 20_000_000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cond_pkg::cond_mode_t mode,
  output cond_pkg::cond_vec_t  cond_sweep,
  output cond_pkg::cond_vec_t  cond_accum,
  output logic [7:0]           mon_sweep
);
  import cond_pkg::*;

  localparam int COND_W = $bits(cond_vec_t);
  localparam int CNT_W  = (PHASE_CYCLES > 1) ? $clog2(PHASE_CYCLES) : 1;

  logic [COND_W-1:0] sweep_cnt;
  logic [CNT_W-1:0]  phase_cnt;
  logic              phase;
  logic              pc_sw;
  logic              phase_end;

  ////////////////////////////////////////////////////////////
  // sweep

  // every switch toggles at some binary rate
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      sweep_cnt <= '0;
    else
      sweep_cnt <= sweep_cnt + 1'b1;
  end

  assign cond_sweep = cond_vec_t'(sweep_cnt);
  assign mon_sweep  = sweep_cnt[7:0];

  ////////////////////////////////////////////////////////////
  // charge accumulation

  assign phase_end = (phase_cnt == CNT_W'(PHASE_CYCLES - 1));

  // parked at phase 0, count 0 in any other mode,
  // so entering accum always starts a fresh ground phase
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      phase_cnt <= '0;
      phase     <= 1'b0;
      pc_sw     <= 1'b0;
    end
    else if (mode != MODE_ACCUM)
    begin
      phase_cnt <= '0;
      phase     <= 1'b0;
      pc_sw     <= 1'b0;
    end
    else
    begin
      // precharge switch toggles every cycle
      pc_sw <= ~pc_sw;
      if (phase_end)
      begin
        phase_cnt <= '0;
        phase     <= ~phase;
      end
      else
        phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // phase 0 grounds the cap, phase 1 connects the source
  always_comb
  begin
    cond_accum.pc_sw  = pc_sw;
    cond_accum.himux2 = phase ? MUX_SRC_HI : MUX_GND;
    cond_accum.himux  = MUX_HIMUX2;
    cond_accum.azmux  = MUX_OFF;
  end

endmodule

/* rtl/cond_mode_mux.sv */
/*
  mode selector
  registered four-way pick of one payload by conditioning mode
*/
module cond_mode_mux #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cond_pkg::cond_mode_t sel,
  input  payload_t             in_off,
  input  payload_t             in_direct,
  input  payload_t             in_sweep,
  input  payload_t             in_accum,
  output payload_t             out
);
  import cond_pkg::*;

  // registered so the pins never glitch during a mode change
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      out <= '0;
    else
    begin
      case (sel)
        MODE_OFF:    out <= in_off;
        MODE_DIRECT: out <= in_direct;
        MODE_SWEEP:  out <= in_sweep;
        MODE_ACCUM:  out <= in_accum;
        default:     out <= in_off;
      endcase
    end
  end

endmodule

/* rtl/dmm_top.sv */
/*
  dmm front-end switching control
  spi register access, pattern generation and mode muxing to the pins
*/
module dmm_top #(
  parameter int PHASE_CYCLES = 20_000_000
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_mosi,
  output logic       spi_miso,
  output logic       led,
  output logic [7:0] mon,
  output logic       sig_pc_sw_ctl,
  output logic [3:0] himux2_ctl,
  output logic [3:0] himux_ctl,
  output logic [3:0] azmux_ctl
);
  import cond_pkg::*;

  cond_mode_t mode;
  cond_vec_t  cond_direct;
  cond_vec_t  cond_sweep;
  cond_vec_t  cond_accum;
  cond_vec_t  cond_out;
  logic [7:0] mon_direct;
  logic [7:0] mon_sweep;
  logic [7:0] mon_accum;

  reg_bus_if bus ();

  ////////////////////////////////////////////////////////////
  // input side and registers

  spi_reg_slave u_spi (
    .clk      (clk),
    .reset    (reset),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .bus      (bus.slave)
  );

  ctrl_regs u_regs (
    .clk         (clk),
    .reset       (reset),
    .bus         (bus.regs),
    .led         (led),
    .mode        (mode),
    .cond_direct (cond_direct),
    .mon_direct  (mon_direct)
  );

  cond_pattern_gen #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) u_pattern (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .cond_sweep (cond_sweep),
    .cond_accum (cond_accum),
    .mon_sweep  (mon_sweep)
  );

  ////////////////////////////////////////////////////////////
  // output side

  // accum monitor shows precharge plus the himux2 phase code
  assign mon_accum = {3'b000, cond_accum.pc_sw, cond_accum.himux2};

  cond_mode_mux #(
    .payload_t (cond_vec_t)
  ) u_cond_mux (
    .clk       (clk),
    .reset     (reset),
    .sel       (mode),
    .in_off    ('0),
    .in_direct (cond_direct),
    .in_sweep  (cond_sweep),
    .in_accum  (cond_accum),
    .out       (cond_out)
  );

  cond_mode_mux #(
    .payload_t (logic [7:0])
  ) u_mon_mux (
    .clk       (clk),
    .reset     (reset),
    .sel       (mode),
    .in_off    (8'h00),
    .in_direct (mon_direct),
    .in_sweep  (mon_sweep),
    .in_accum  (mon_accum),
    .out       (mon)
  );

  // split the vector out to the switch pins
  assign sig_pc_sw_ctl = cond_out.pc_sw;
  assign himux2_ctl    = cond_out.himux2;
  assign himux_ctl     = cond_out.himux;
  assign azmux_ctl     = cond_out.azmux;

endmodule

/* tb/dmm_checker.sv */
/*
  register bus checker
  bound into the register file, watches the write handshake and reset values
*/
module dmm_checker (
  input logic                 clk,
  input logic                 reset,
  input logic                 req,
  input logic                 ack,
  input logic                 led,
  input cond_pkg::cond_mode_t mode,
  input cond_pkg::cond_vec_t  cond_direct,
  input logic [7:0]           mon_direct
);
  timeunit 1ns;
  timeprecision 1ps;

  // read by the testbench at the end of the run
  int assert_fails = 0;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
    else
    begin
      assert_fails++;
      $error("ack rose while req was low");
    end

  // request is held until the register file answers
  req_held: assert property (@(posedge clk) disable iff (reset) (req && !ack) |=> req)
    else
    begin
      assert_fails++;
      $error("req dropped before ack");
    end

  // everything cleared while reset is high
  reset_clear: assert property (@(posedge clk)
    reset |-> (!req && !ack && !led && mode == 2'd0 && cond_direct == '0 && mon_direct == '0))
    else
    begin
      assert_fails++;
      $error("register outputs not zero during reset");
    end

endmodule

bind ctrl_regs dmm_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .req         (bus.req),
  .ack         (bus.ack),
  .led         (led),
  .mode        (mode),
  .cond_direct (cond_direct),
  .mon_direct  (mon_direct)
);

/* tb/dmm_tb.sv */
/*
  dmm switching control testbench
  replays the tests file as spi frames and mode checks against the pins
*/
module dmm_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cond_pkg::*;

  localparam int PHASE_CYCLES = 8;
  localparam int MAX_TESTS    = 64;
  localparam int FRAME_BITS   = 32;
  // spi bit is 8 clk cycles, half low and half high
  localparam int HALF_BIT     = 4;
  // committed write reaches the pins within this many cycles of cs rising
  localparam int SETTLE       = 8;

  logic        clk;
  logic        reset;
  logic        spi_clk;
  logic        spi_cs;
  logic        spi_mosi;
  logic        spi_miso;
  logic        led;
  logic [7:0]  mon;
  logic        sig_pc_sw_ctl;
  logic [3:0]  himux2_ctl;
  logic [3:0]  himux_ctl;
  logic [3:0]  azmux_ctl;

  // record: kind, address or mode, data, bit or cycle count
  logic [47:0] tests [0:MAX_TESTS-1];
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  bit          limit_ready = 1'b0;

  // expected register contents, updated by every full frame
  logic        shadow_led;
  logic [1:0]  shadow_mode;
  logic [12:0] shadow_cond;
  logic [7:0]  shadow_mon;

  dmm_top #(
    .PHASE_CYCLES (PHASE_CYCLES)
  ) DUT (
    .clk           (clk),
    .reset         (reset),
    .spi_clk       (spi_clk),
    .spi_cs        (spi_cs),
    .spi_mosi      (spi_mosi),
    .spi_miso      (spi_miso),
    .led           (led),
    .mon           (mon),
    .sig_pc_sw_ctl (sig_pc_sw_ctl),
    .himux2_ctl    (himux2_ctl),
    .himux_ctl     (himux_ctl),
    .azmux_ctl     (azmux_ctl)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // cycle limit from the test lengths
  initial
  begin
    cycle_cnt = 0;
    wait (limit_ready);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests still running after %0d clock cycles", cycle_limit);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_mismatch(input string name, input logic [23:0] got,
                                 input logic [23:0] exp);
    $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_failure(input string msg);
    $display("at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string label, input int errs_before);
    if (err_cnt == errs_before)
    begin
      pass_cnt++;
      $display("test %s: ok", label);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: failed", label);
    end
  endtask

  // cs setup, clocked bits, trailing low half bit, then settle
  function automatic int frame_cycles(input int bits);
    return HALF_BIT + bits * 2 * HALF_BIT + HALF_BIT + SETTLE;
  endfunction

  // register map from the address decode rules
  task automatic apply_write(input logic [7:0] addr, input logic [23:0] data);
    case (addr)
      8'd1: shadow_led  = data[0];
      8'd2: shadow_mode = data[1:0];
      8'd3: shadow_cond = data[12:0];
      8'd4: shadow_mon  = data[7:0];
      default: ;
    endcase
  endtask

  // read-back word of a mapped register, upper bits zero
  function automatic logic [23:0] expected_reg(input logic [7:0] addr);
    logic [23:0] val;
    val = '0;
    case (addr)
      8'd1: val[0]    = shadow_led;
      8'd2: val[1:0]  = shadow_mode;
      8'd3: val[12:0] = shadow_cond;
      8'd4: val[7:0]  = shadow_mon;
      default: ;
    endcase
    return val;
  endfunction

  // mode 0 spi, mosi set with the falling half, miso sampled just before rising
  task automatic send_frame(input logic [31:0] word, input int bits,
                            output logic [23:0] rd);
    rd     = '0;
    spi_cs = 1'b0;
    wait_cycles(HALF_BIT);
    for (int i = 0; i < bits; i++)
    begin
      spi_clk  = 1'b0;
      spi_mosi = (i < FRAME_BITS) ? word[FRAME_BITS-1-i] : 1'b0;
      wait_cycles(HALF_BIT);
      // read data follows the address byte
      if (i >= 8 && i < FRAME_BITS)
        rd = {rd[22:0], spi_miso};
      spi_clk = 1'b1;
      wait_cycles(HALF_BIT);
    end
    spi_clk = 1'b0;
    wait_cycles(HALF_BIT);
    spi_cs = 1'b1;
    wait_cycles(SETTLE);
  endtask

  // read every mapped register back, each frame rewriting the expected value
  task automatic verify_registers();
    logic [23:0] rd;
    logic [23:0] exp;
    for (int a = 1; a <= 4; a++)
    begin
      exp = expected_reg(8'(a));
      send_frame({8'(a), exp}, FRAME_BITS, rd);
      if (rd !== exp)
        report_mismatch($sformatf("register %0d read data", a), rd, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // per-mode pin checks

  task automatic check_mode(input logic [7:0] m, input int cycles);
    logic [12:0] vec;
    logic [12:0] prev_vec;
    logic        prev_pc;
    logic [3:0]  run_code;
    logic [3:0]  next_code;
    int          run_len;
    bit          first_run;
    prev_vec  = '0;
    prev_pc   = 1'b0;
    run_code  = '0;
    run_len   = 0;
    first_run = 1'b1;
    for (int c = 0; c < cycles; c++)
    begin
      @(negedge clk);
      vec = {sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl};
      case (m)
        8'd0:
        begin
          if (vec !== 13'd0)
            report_mismatch("conditioning pins", vec, 0);
          if (mon !== 8'd0)
            report_mismatch("mon", mon, 0);
        end
        8'd1:
        begin
          if (vec !== shadow_cond)
            report_mismatch("conditioning pins", vec, shadow_cond);
          if (led !== shadow_led)
            report_mismatch("led", led, shadow_led);
          if (mon !== shadow_mon)
            report_mismatch("mon", mon, shadow_mon);
        end
        8'd2:
        begin
          // pins as one 13-bit count
          if (c > 0 && vec !== 13'(prev_vec + 13'd1))
            report_mismatch("conditioning pins", vec, 13'(prev_vec + 13'd1));
          if (mon !== vec[7:0])
            report_mismatch("mon", mon, vec[7:0]);
        end
        8'd3:
        begin
          if (himux_ctl !== MUX_HIMUX2)
            report_mismatch("himux_ctl", himux_ctl, MUX_HIMUX2);
          if (azmux_ctl !== MUX_OFF)
            report_mismatch("azmux_ctl", azmux_ctl, MUX_OFF);
          if (c > 0 && sig_pc_sw_ctl !== ~prev_pc)
            report_mismatch("sig_pc_sw_ctl", sig_pc_sw_ctl, ~prev_pc);
          if (mon !== {3'b000, sig_pc_sw_ctl, himux2_ctl})
            report_mismatch("mon", mon, {3'b000, sig_pc_sw_ctl, himux2_ctl});
          // phase runs, the first one may be partial
          if (c == 0)
          begin
            if (himux2_ctl !== MUX_GND && himux2_ctl !== MUX_SRC_HI)
              report_failure("himux2 is neither ground nor source at check start");
            run_code = himux2_ctl;
            run_len  = 1;
          end
          else if (himux2_ctl === run_code)
          begin
            run_len++;
            if (run_len == PHASE_CYCLES + 1)
              report_failure("himux2 held one phase code longer than a phase");
          end
          else
          begin
            next_code = (run_code == MUX_GND) ? MUX_SRC_HI : MUX_GND;
            if (himux2_ctl !== next_code)
              report_mismatch("himux2_ctl", himux2_ctl, next_code);
            if (!first_run && run_len != PHASE_CYCLES)
              report_failure($sformatf("himux2 phase lasted %0d cycles", run_len));
            run_code  = himux2_ctl;
            run_len   = 1;
            first_run = 1'b0;
          end
        end
        default: report_failure($sformatf("unknown mode %0d in tests file", m));
      endcase
      prev_vec = vec;
      prev_pc  = sig_pc_sw_ctl;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    logic [3:0]  kind;
    logic [7:0]  addr;
    logic [23:0] data;
    logic [11:0] count;
    logic [23:0] rd;
    int          errs_before;
    string       label;
    reset       = 1'b1;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_mosi    = 1'b0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    shadow_led  = 1'b0;
    shadow_mode = '0;
    shadow_cond = '0;
    shadow_mon  = '0;
    for (int i = 0; i < MAX_TESTS; i++)
      tests[i] = '0;
    $readmemh("tb/dmm_tests.txt", tests);

    // reset, reset check and margin, then every record
    cycle_limit = 10 + 2 + 200;
    for (int t = 0; t < MAX_TESTS && tests[t][47:44] != 4'd0; t++)
    begin
      if (tests[t][47:44] == 4'd3)
        cycle_limit += frame_cycles(int'(tests[t][11:0])) + 4 * frame_cycles(FRAME_BITS);
      else if (tests[t][47:44] == 4'd4)
        cycle_limit += int'(tests[t][11:0]) + 2;
      else
        cycle_limit += frame_cycles(FRAME_BITS);
    end
    limit_ready = 1'b1;

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    errs_before = err_cnt;
    if ({sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl} !== 13'd0)
      report_mismatch("conditioning pins", {sig_pc_sw_ctl, himux2_ctl, himux_ctl, azmux_ctl}, 0);
    if (mon !== 8'd0)
      report_mismatch("mon", mon, 0);
    if (led !== 1'b0)
      report_mismatch("led", led, 0);
    if (spi_miso !== 1'b0)
      report_mismatch("spi_miso", spi_miso, 0);
    finish_test("reset values", errs_before);

    for (int t = 0; t < MAX_TESTS && tests[t][47:44] != 4'd0; t++)
    begin
      kind        = tests[t][47:44];
      addr        = tests[t][43:36];
      data        = tests[t][35:12];
      count       = tests[t][11:0];
      errs_before = err_cnt;
      case (kind)
        4'd1:
        begin
          label = $sformatf("%0d write %h <- %h", t, addr, data);
          send_frame({addr, data}, FRAME_BITS, rd);
          apply_write(addr, data);
        end
        4'd2:
        begin
          // the read frame writes back the expected value
          label = $sformatf("%0d read %h", t, addr);
          send_frame({addr, data}, FRAME_BITS, rd);
          apply_write(addr, data);
          if (rd !== data)
            report_mismatch("spi_miso read data", rd, data);
        end
        4'd3:
        begin
          label = $sformatf("%0d %0d-bit frame to %h", t, count, addr);
          send_frame({addr, data}, int'(count), rd);
          // a discarded frame leaves every register as it was
          verify_registers();
        end
        4'd4:
        begin
          label = $sformatf("%0d mode %0d for %0d cycles", t, addr, count);
          check_mode(addr, int'(count));
        end
        default:
        begin
          label = $sformatf("%0d", t);
          report_failure($sformatf("unknown record kind %0d in tests file", kind));
        end
      endcase
      finish_test(label, errs_before);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, DUT.u_regs.u_checker.assert_fails);
    if (fail_cnt == 0 && DUT.u_regs.u_checker.assert_fails == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* tb/dmm_tests.txt */
// kind _ addr or mode _ data or expected _ bit or cycle count, all hex
// kind 1 write, 2 read, 3 short or long frame, 4 mode check (mode 0 off 1 direct 2 sweep 3 accum)
4_00_000000_004
1_01_000001_000
1_04_0000a5_000
1_03_001abc_000
2_01_000001_000
2_03_001abc_000
2_04_0000a5_000
1_07_123456_000
2_07_000000_000
3_04_00005a_01f
3_03_000fff_021
2_04_0000a5_000
2_03_001abc_000
1_02_000001_000
2_02_000001_000
4_01_000000_010
1_02_000002_000
4_02_000000_020
1_02_000003_000
4_03_000000_030
1_02_000000_000
4_00_000000_008

/* flist.f */
common/dmm_regs_pkg.sv
common/cond_pkg.sv
common/reg_bus_if.sv
spi/spi_reg_slave.sv
rtl/ctrl_regs.sv
rtl/cond_pattern_gen.sv
rtl/cond_mode_mux.sv
rtl/dmm_top.sv
tb/dmm_checker.sv
tb/dmm_tb.sv
